//--- verilog/cpuControlPkg.sv
// ----------------------------------------------------------------------
// Opcode, device, target and flag encodings of the 8-bit control unit.
// Field widths are fixed by the instruction format. Jump targets must
// stay in the same order as the flag bits they test.
// ----------------------------------------------------------------------
`default_nettype none

package cpuControlPkg;

    localparam int numDevs    = 16;
    localparam int numTargets = 32;
    localparam int numFlags   = 10;

    typedef logic [2:0]          opcode_t;
    typedef logic [3:0]          dev_t;
    typedef logic [4:0]          target_t;
    typedef logic [numFlags-1:0] flags_t;

    // instruction word as it comes out of program ROM
    typedef struct packed {
        opcode_t    opcode;
        target_t    target;
        dev_t       aDev;
        dev_t       bDev;
        logic [7:0] operand;
    } instrWord_t;

    localparam opcode_t opXyAlu          = 3'd0;
    localparam opcode_t opConst8         = 3'd1;
    localparam opcode_t opConst16        = 3'd2;
    localparam opcode_t opUnused3        = 3'd3;
    localparam opcode_t opRomDirect      = 3'd4;
    localparam opcode_t opRamDirect      = 3'd5;
    localparam opcode_t opRamDirectEqDev = 3'd6;
    localparam opcode_t opUnused7        = 3'd7;

    // source devices, also the low half of the target space
    localparam dev_t devRegA    = 4'd0;
    localparam dev_t devRegB    = 4'd1;
    localparam dev_t devRegC    = 4'd2;
    localparam dev_t devRegD    = 4'd3;
    localparam dev_t devRegE    = 4'd4;
    localparam dev_t devRegF    = 4'd5;
    localparam dev_t devRegG    = 4'd6;
    localparam dev_t devRegH    = 4'd7;
    localparam dev_t devFlags   = 4'd8;
    localparam dev_t devInstReg = 4'd9;
    localparam dev_t devRam     = 4'd10;
    localparam dev_t devRom     = 4'd11;
    localparam dev_t devMarLo   = 4'd12;
    localparam dev_t devMarHi   = 4'd13;
    localparam dev_t devUart    = 4'd14;
    localparam dev_t devNotUsed = 4'd15;

    // target-only codes, 29 to 31 unused
    localparam target_t tgtPcHiTmp = 5'd16;
    localparam target_t tgtPcLo    = 5'd17;
    localparam target_t tgtPc      = 5'd18;
    localparam target_t tgtJmpC    = 5'd19;
    localparam target_t tgtJmpZ    = 5'd20;
    localparam target_t tgtJmpO    = 5'd21;
    localparam target_t tgtJmpN    = 5'd22;
    localparam target_t tgtJmpGt   = 5'd23;
    localparam target_t tgtJmpLt   = 5'd24;
    localparam target_t tgtJmpEq   = 5'd25;
    localparam target_t tgtJmpNe   = 5'd26;
    localparam target_t tgtJmpDi   = 5'd27;
    localparam target_t tgtJmpDo   = 5'd28;

    localparam int flgCarry     = 0;
    localparam int flgZero      = 1;
    localparam int flgOverflow  = 2;
    localparam int flgNegative  = 3;
    localparam int flgGt        = 4;
    localparam int flgLt        = 5;
    localparam int flgEq        = 6;
    localparam int flgNe        = 7;
    localparam int flgDataIn    = 8;
    localparam int flgDataOut   = 9;

endpackage

`default_nettype wire

//--- verilog/ctrlBus.sv
// ----------------------------------------------------------------------
// Latched instruction fields. Stable from the edge that ends fetch
// until the next one.
// ----------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

interface ctrlBus;

    import cpuControlPkg::*;

    opcode_t    opcode;
    target_t    target;
    dev_t       aDev;
    dev_t       bDev;
    logic [7:0] operand;

    modport writer
    (
        output opcode, target, aDev, bDev, operand
    );

    modport reader
    (
        input opcode, target, aDev, bDev, operand
    );

endinterface

`default_nettype wire

//--- verilog/phaseSequencer.sv
// ----------------------------------------------------------------------
// One-hot fetch/decode/exec ring, one cycle per phase, no stall.
// Idle (all low) during reset, fetch on the first edge after release.
// ----------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module phaseSequencer
(
    input  logic clk,
    input  logic rstN,
    output logic phaseFetch,
    output logic phaseDecode,
    output logic phaseExec
);

    localparam logic [2:0] stNone   = 3'b000;
    localparam logic [2:0] stFetch  = 3'b100;
    localparam logic [2:0] stDecode = 3'b010;
    localparam logic [2:0] stExec   = 3'b001;

    logic [2:0] phase;
    logic [2:0] phaseNext;

    always_comb
    begin
        case (phase)
            stNone:   phaseNext = stFetch;
            stFetch:  phaseNext = stDecode;
            stDecode: phaseNext = stExec;
            stExec:   phaseNext = stFetch;
            // illegal codes fall back into fetch
            default:  phaseNext = stFetch;
        endcase
    end

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
            phase <= stNone;
        else
            phase <= phaseNext;
    end

    assign phaseFetch  = phase[2];
    assign phaseDecode = phase[1];
    assign phaseExec   = phase[0];

endmodule

`default_nettype wire

//--- verilog/instructionRegister.sv
// ----------------------------------------------------------------------
// Captures the ROM word on the edge that ends fetch. Fields are valid
// in decode and exec, one cycle after instr was presented.
// ----------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module instructionRegister
(
    input  logic                     clk,
    input  logic                     rstN,
    input  logic                     phaseFetch,
    input  cpuControlPkg::instrWord_t instr,
    ctrlBus.writer                   bus
);

    import cpuControlPkg::*;

    instrWord_t ir;

    // load only while fetch is up, hold through decode and exec
    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            ir <= '0;
        end
        else if (phaseFetch)
        begin
            ir <= instr;
        end
    end

    assign bus.opcode  = ir.opcode;
    assign bus.target  = ir.target;
    assign bus.aDev    = ir.aDev;
    assign bus.bDev    = ir.bDev;
    assign bus.operand = ir.operand;

endmodule

`default_nettype wire

//--- verilog/deviceSelect.sv
// ----------------------------------------------------------------------
// Active-low selects, combinational from the latched fields. Selects
// only go low while phaseExec is high. Flags must be valid in exec.
// Exactly one address-mode strobe is low at any time.
// ----------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module deviceSelect
(
    ctrlBus.reader                          bus,
    input  logic                            phaseExec,
    input  cpuControlPkg::flags_t           flags,
    output logic [cpuControlPkg::numDevs-1:0]    aSelN,
    output logic [cpuControlPkg::numDevs-1:0]    bSelN,
    output logic [cpuControlPkg::numTargets-1:0] targSelN,
    output logic                            immedEnN,
    output logic                            addrModePcN,
    output logic                            addrModeRegN,
    output logic                            addrModeDirN
);

    import cpuControlPkg::*;

    logic [numDevs-1:0]    aSel;
    logic [numDevs-1:0]    bSel;
    logic [numTargets-1:0] targReq;
    logic [numTargets-1:0] targGate;
    logic                  immedEn;
    logic                  isDirect;

    // active-high requests per opcode, exec only
    always_comb
    begin
        aSel    = '0;
        bSel    = '0;
        targReq = '0;
        immedEn = 1'b0;
        if (phaseExec)
        begin
            case (bus.opcode)
                opXyAlu:
                begin
                    aSel[bus.aDev]      = 1'b1;
                    bSel[bus.bDev]      = 1'b1;
                    targReq[bus.target] = 1'b1;
                end
                opConst8, opConst16:
                begin
                    immedEn             = 1'b1;
                    targReq[bus.target] = 1'b1;
                end
                opRomDirect:
                begin
                    bSel[devRom]        = 1'b1;
                    targReq[bus.target] = 1'b1;
                end
                opRamDirect:
                begin
                    bSel[devRam]        = 1'b1;
                    targReq[bus.target] = 1'b1;
                end
                opRamDirectEqDev:
                begin
                    bSel[bus.bDev]          = 1'b1;
                    targReq[{1'b0, devRam}] = 1'b1;
                end
                default:
                begin
                    // unused opcodes select nothing
                end
            endcase
        end
    end

    // devices and pc loads always pass, jumps follow their flag
    always_comb
    begin
        targGate                       = '0;
        targGate[tgtJmpC-1:0]          = '1;
        targGate[tgtJmpC +: numFlags]  = flags;
    end

    assign aSelN    = ~aSel;
    assign bSelN    = ~bSel;
    assign targSelN = ~(targReq & targGate);
    assign immedEnN = ~immedEn;

    assign isDirect = (bus.opcode == opRomDirect) ||
                      (bus.opcode == opRamDirect) ||
                      (bus.opcode == opRamDirectEqDev);

    // pc mode covers fetch, decode and the idle state
    assign addrModePcN  = phaseExec;
    assign addrModeDirN = ~(phaseExec & isDirect);
    assign addrModeRegN = ~(phaseExec & ~isDirect);

endmodule

`default_nettype wire

//--- verilog/controlTop.sv
// ----------------------------------------------------------------------
// Control unit top. instr is sampled in fetch, flags are used in exec.
// All selects and strobes are active low.
// ----------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module controlTop
(
    input  logic                                 clk,
    input  logic                                 rstN,
    input  cpuControlPkg::instrWord_t            instr,
    input  cpuControlPkg::flags_t                flags,
    output logic                                 phaseFetch,
    output logic                                 phaseDecode,
    output logic                                 phaseExec,
    output logic [cpuControlPkg::numDevs-1:0]    aSelN,
    output logic [cpuControlPkg::numDevs-1:0]    bSelN,
    output logic [cpuControlPkg::numTargets-1:0] targSelN,
    output logic                                 immedEnN,
    output logic                                 addrModePcN,
    output logic                                 addrModeRegN,
    output logic                                 addrModeDirN,
    output logic [7:0]                           operand
);

    ctrlBus ctrl ();

    phaseSequencer uPhase
    (
        .clk         (clk),
        .rstN        (rstN),
        .phaseFetch  (phaseFetch),
        .phaseDecode (phaseDecode),
        .phaseExec   (phaseExec)
    );

    instructionRegister uIr
    (
        .clk        (clk),
        .rstN       (rstN),
        .phaseFetch (phaseFetch),
        .instr      (instr),
        .bus        (ctrl.writer)
    );

    deviceSelect uSel
    (
        .bus          (ctrl.reader),
        .phaseExec    (phaseExec),
        .flags        (flags),
        .aSelN        (aSelN),
        .bSelN        (bSelN),
        .targSelN     (targSelN),
        .immedEnN     (immedEnN),
        .addrModePcN  (addrModePcN),
        .addrModeRegN (addrModeRegN),
        .addrModeDirN (addrModeDirN)
    );

    // immediate byte straight from the latched word
    assign operand = ctrl.operand;

endmodule

`default_nettype wire

//--- sim/controlTb.sv
// ----------------------------------------------------------------------
// Directed testbench for controlTop. Inputs change on the falling edge
// and outputs are sampled there. One instruction takes 3 cycles.
// ----------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module controlTb;

    import cpuControlPkg::*;

    localparam int numInstr   = 88;
    localparam int cycleLimit = 3 * numInstr + 16 + 12 + 100;

    logic                  clk;
    logic                  rstN;
    instrWord_t            instr;
    flags_t                flags;
    logic                  phaseFetch;
    logic                  phaseDecode;
    logic                  phaseExec;
    logic [numDevs-1:0]    aSelN;
    logic [numDevs-1:0]    bSelN;
    logic [numTargets-1:0] targSelN;
    logic                  immedEnN;
    logic                  addrModePcN;
    logic                  addrModeRegN;
    logic                  addrModeDirN;
    logic [7:0]            operand;
    logic [31:0]           lfsr;
    int                    cycles = 0;
    int                    checks = 0;
    int                    errors = 0;

    controlTop u_dut (.*);

    always #20 clk = ~clk;

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles >= cycleLimit)
        begin
            $display("Timeout: %0d cycles passed and the tests did not end", cycleLimit);
            $display("Checks failed");
            $finish;
        end
    end

    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one LFSR step per returned bit
    task automatic randomBits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsrNext(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic checkEq(input logic [31:0] got, input logic [31:0] expected, input string what);
        checks++;
        if (got !== expected)
        begin
            errors++;
            $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, expected);
        end
    endtask

    // flag bit tested by a jump target or -1
    function automatic int jumpFlag(input target_t t);
        case (t)
            tgtJmpC:  return flgCarry;
            tgtJmpZ:  return flgZero;
            tgtJmpO:  return flgOverflow;
            tgtJmpN:  return flgNegative;
            tgtJmpGt: return flgGt;
            tgtJmpLt: return flgLt;
            tgtJmpEq: return flgEq;
            tgtJmpNe: return flgNe;
            tgtJmpDi: return flgDataIn;
            tgtJmpDo: return flgDataOut;
            default:  return -1;
        endcase
    endfunction

    // expected exec selects with a in the upper half of ab
    task automatic expectSel(input instrWord_t w, input flags_t f, output logic [31:0] ab,
                             output logic [31:0] tg, output logic imm);
        target_t req;
        logic    reqOn;
        int      jf;
        ab    = '1;
        tg    = '1;
        imm   = 1'b1;
        req   = w.target;
        reqOn = 1'b1;
        case (w.opcode)
            opXyAlu:
            begin
                ab[{1'b1, w.aDev}] = 1'b0;
                ab[{1'b0, w.bDev}] = 1'b0;
            end
            opConst8, opConst16: imm = 1'b0;
            opRomDirect:         ab[{1'b0, devRom}] = 1'b0;
            opRamDirect:         ab[{1'b0, devRam}] = 1'b0;
            opRamDirectEqDev:
            begin
                ab[{1'b0, w.bDev}] = 1'b0;
                req                = {1'b0, devRam};
            end
            default:             reqOn = 1'b0;
        endcase
        jf = jumpFlag(req);
        if (reqOn && jf < 0 && req <= tgtPc)
            tg[req] = 1'b0;
        else if (reqOn && jf >= 0 && f[jf[3:0]])
            tg[req] = 1'b0;
    endtask

    task automatic checkPhase(input logic [2:0] expected, input string where);
        checkEq(32'({phaseFetch, phaseDecode, phaseExec}), 32'(expected), {where, " phase"});
    endtask

    task automatic checkIdle(input string where);
        checkEq({aSelN, bSelN}, 32'hffff_ffff, {where, " a/b selects"});
        checkEq(targSelN, 32'hffff_ffff, {where, " target selects"});
        checkEq(32'({immedEnN, addrModePcN, addrModeRegN, addrModeDirN}), 32'hb,
                {where, " strobes"});
    endtask

    task automatic runInstr(input instrWord_t w, input flags_t f);
        logic [31:0] expAb;
        logic [31:0] expT;
        logic        expImm;
        logic        isDir;
        string       tag;
        tag   = $sformatf("opcode %0d target %0d", w.opcode, w.target);
        isDir = (w.opcode == opRomDirect) || (w.opcode == opRamDirect) ||
                (w.opcode == opRamDirectEqDev);
        expectSel(w, f, expAb, expT, expImm);
        @(negedge clk);
        while (!phaseFetch)
            @(negedge clk);
        instr = w;
        checkIdle({tag, " fetch"});
        @(negedge clk);
        checkPhase(3'b010, {tag, " decode"});
        checkIdle({tag, " decode"});
        checkEq(32'(operand), 32'(w.operand), {tag, " decode operand"});
        // ROM output no longer valid after fetch
        instr = ~w;
        flags = f;
        @(negedge clk);
        checkPhase(3'b001, {tag, " exec"});
        checkEq({aSelN, bSelN}, expAb, {tag, " exec a/b selects"});
        checkEq(targSelN, expT, {tag, " exec target selects"});
        checkEq(32'({immedEnN, addrModePcN, addrModeRegN, addrModeDirN}),
                32'({expImm, 1'b1, isDir, !isDir}), {tag, " exec strobes"});
        checkEq(32'(operand), 32'(w.operand), {tag, " exec operand"});
    endtask

    // random devices, operand and flags around a fixed opcode and target
    task automatic runRandom(input opcode_t op, input target_t tg, input int forceFlag,
                             input logic forceVal);
        logic [31:0] r;
        logic [31:0] fr;
        flags_t      f;
        randomBits(16, r);
        randomBits(10, fr);
        f = fr[9:0];
        if (forceFlag >= 0)
            f[forceFlag[3:0]] = forceVal;
        runInstr({op, tg, r[15:0]}, f);
    endtask

    task automatic reportTest(input string name, input int e0);
        $display("%s finished, %0d errors", name, errors - e0);
    endtask

    task automatic testReset();
        int         e0;
        logic [2:0] ring;
        e0 = errors;
        repeat (16)
        begin
            @(negedge clk);
            checkPhase(3'b000, "reset");
            checkIdle("reset");
        end
        @(negedge clk);
        rstN = 1'b1;
        checkPhase(3'b000, "release");
        checkIdle("release");
        ring = 3'b100;
        repeat (12)
        begin
            @(negedge clk);
            checkPhase(ring, "ring");
            ring = {ring[0], ring[2:1]};
        end
        reportTest("reset and phase ring", e0);
    endtask

    task automatic testAlu();
        int          e0;
        logic [31:0] r;
        e0 = errors;
        repeat (40)
        begin
            randomBits(4, r);
            runRandom(opXyAlu, {1'b0, r[3:0]}, -1, 1'b0);
        end
        reportTest("alu moves", e0);
    endtask

    task automatic runGroup(input opcode_t op, input int count);
        logic [31:0] r;
        repeat (count)
        begin
            randomBits(4, r);
            runRandom(op, {1'b0, r[3:0]}, -1, 1'b0);
        end
    endtask

    task automatic testConstDirect();
        int e0;
        e0 = errors;
        runGroup(opConst8, 4);
        runGroup(opConst16, 4);
        runGroup(opRomDirect, 4);
        runGroup(opRamDirect, 4);
        runGroup(opRamDirectEqDev, 4);
        reportTest("constants and direct addressing", e0);
    endtask

    task automatic testJumps();
        int e0;
        e0 = errors;
        for (target_t t = tgtJmpC; t <= tgtJmpDo; t++)
        begin
            runRandom(opXyAlu, t, jumpFlag(t), 1'b0);
            runRandom(opXyAlu, t, jumpFlag(t), 1'b1);
        end
        runRandom(opXyAlu, tgtPc, -1, 1'b0);
        runRandom(opXyAlu, 5'd29, -1, 1'b0);
        runRandom(opXyAlu, 5'd30, -1, 1'b0);
        runRandom(opXyAlu, 5'd31, -1, 1'b0);
        reportTest("conditional jumps", e0);
    endtask

    task automatic testUnused();
        int e0;
        e0 = errors;
        runGroup(opUnused3, 2);
        runGroup(opUnused7, 2);
        reportTest("unused opcodes", e0);
    endtask

    initial
    begin
        clk   = 1'b0;
        rstN  = 1'b0;
        instr = '0;
        flags = '0;
        lfsr  = 32'hf6a3;
        testReset();
        testAlu();
        testConstDirect();
        testJumps();
        testUnused();
        $display("Done: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
verilog/cpuControlPkg.sv
verilog/ctrlBus.sv
verilog/phaseSequencer.sv
verilog/instructionRegister.sv
verilog/deviceSelect.sv
verilog/controlTop.sv
sim/controlTb.sv

//--- Makefile
# Verilator build and run of the control unit testbench

VERILATOR ?= verilator
TOP       ?= controlTb
FLIST     ?= sources.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
FAILMSG   ?= Checks failed
VFLAGS    ?= --binary --timing

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR)

run: $(BIN)
	@$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAILMSG)" $(LOG); then \
		echo "simulation FAILED, see $(LOG)"; exit 1; \
	else \
		echo "simulation ok"; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)
